//--- verif/timer_tests.txt
# op addr data expect slack irq; addr, data and expect in hex, slack and irq in decimal
# W write acked, E write answered with err, R read compared, T wait data ticks
R 00 00000000 00000000 0 0
R 04 00000000 00000000 0 0
R 10 00000000 00000000 0 0
R 14 00000000 00000000 0 0
R 20 00000000 00000000 0 0
R 24 00000000 00000000 0 0
R 30 00000000 00000000 0 0
R 34 00000000 00000000 0 0
R 40 00000000 00000000 0 0
W 00 00000020 00000000 0 0
W 10 00000003 00000000 0 0
W 20 00000007 00000000 0 0
W 30 00123456 00000000 0 0
R 00 00000000 00000020 0 0
R 10 00000000 00000003 0 0
R 20 00000000 00000007 0 0
R 30 00000000 00123456 0 0
R 34 00000000 00000000 0 0
E 30 00006000 00000000 0 0
R 30 00000000 00123456 0 0
W 04 00000001 00000000 0 0
T 00 00000005 00000000 0 0
W 04 00000002 00000000 0 0
R 00 00000000 00000015 1 0
R 04 00000000 00000000 0 0
W 14 00000001 00000000 0 0
T 00 00000006 00000000 0 0
R 14 00000000 00000002 0 1
R 10 00000000 00000000 0 1
R 40 00000000 00000002 0 1
R 20 00000000 00000007 0 1
W 40 00000002 00000000 0 1
R 40 00000000 00000000 0 0
W 10 00000003 00000000 0 0
R 14 00000000 00000000 0 0
R 10 00000000 00000003 0 0

//--- verilog.f
+incdir+include
logic/timer_pkg.sv
logic/wb_pkg.sv
logic/tick_gen.sv
logic/timer_regs.sv
logic/timer_channel.sv
logic/alarm_collect.sv
logic/timer_top.sv
verif/timer_checker.sv
verif/timer_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = timer_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/timer_tb.sv
// Timer bank testbench
`timescale 1ns/1ps
`default_nettype none

module timer_tb;

  import wb_pkg::*;

  localparam int TICKS_PER_SECOND = 8;
  localparam int CLK_PERIOD = 20;

  logic       clk_50M;
  logic       rst_n;
  logic       cyc;
  logic       stb;
  logic       we;
  wb_addr_t   adr;
  wb_sel_t    sel;
  wb_data_t   dat_w;
  wb_data_t   dat_r;
  logic       ack;
  logic       err;
  logic       irq;

  // expectations handed to the checker
  logic [7:0] cur_op;
  wb_addr_t   cur_adr;
  wb_data_t   cur_exp;
  int         cur_slack;
  logic       cur_irq;
  logic       done;
  int         pass_count;
  int         fail_count;

  byte        op_q[$];
  wb_addr_t   adr_q[$];
  wb_data_t   data_q[$];
  wb_data_t   exp_q[$];
  int         slack_q[$];
  logic       irq_q[$];
  int         setup_errors;
  int         limit_ns;

  timer_top #(
    .ticks_per_second(TICKS_PER_SECOND)
  ) dut_i (
    .clk_50M(clk_50M),
    .rst_n  (rst_n),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .sel    (sel),
    .dat_w  (dat_w),
    .dat_r  (dat_r),
    .ack    (ack),
    .err    (err),
    .irq    (irq)
  );

  timer_checker checker_i (
    .clk_50M   (clk_50M),
    .rst_n     (rst_n),
    .ack       (ack),
    .err       (err),
    .irq       (irq),
    .dat_r     (dat_r),
    .exp_op    (cur_op),
    .exp_adr   (cur_adr),
    .exp_data  (cur_exp),
    .exp_slack (cur_slack),
    .exp_irq   (cur_irq),
    .done      (done),
    .pass_count(pass_count),
    .fail_count(fail_count)
  );

  initial begin
    clk_50M = 1'b0;
    forever #(CLK_PERIOD / 2) clk_50M = ~clk_50M;
  end

  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("run timed out after %0d ns without finishing the test list", limit_ns);
    $display("Test failed");
    $finish;
  end

  task automatic load_tests();
    int         fd;
    int         n;
    int         slack;
    int         irq_exp;
    string      line;
    byte        op;
    wb_addr_t   a;
    wb_data_t   d;
    wb_data_t   e;
    fd = $fopen("verif/timer_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/timer_tests.txt");
      setup_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %d %d", op, a, d, e, slack, irq_exp);
      if (n != 6) begin
        $display("malformed test line: %s", line);
        setup_errors++;
      end else begin
        op_q.push_back(op);
        adr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(e);
        slack_q.push_back(slack);
        irq_q.push_back(irq_exp != 0);
      end
    end
    $fclose(fd);
  endtask

  // one classic cycle, held one edge past the answer, then one idle cycle
  task automatic bus_cycle(input int idx);
    cur_op    = op_q[idx];
    cur_adr   = adr_q[idx];
    cur_exp   = exp_q[idx];
    cur_slack = slack_q[idx];
    cur_irq   = irq_q[idx];
    cyc       = 1'b1;
    stb       = 1'b1;
    we        = (op_q[idx] != "R");
    adr       = adr_q[idx];
    dat_w     = data_q[idx];
    do begin
      @(posedge clk_50M);
      #2;
    end while (!(ack || err));
    @(posedge clk_50M);
    #2;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(posedge clk_50M);
    #2;
  endtask

  initial begin : run_tests
    int total_ticks;
    int i;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    sel          = 4'hf;
    dat_w        = '0;
    rst_n        = 1'b0;
    done         = 1'b0;
    cur_op       = "R";
    cur_adr      = '0;
    cur_exp      = '0;
    cur_slack    = 0;
    cur_irq      = 1'b0;
    setup_errors = 0;
    limit_ns     = 0;
    total_ticks  = 0;
    load_tests();
    for (i = 0; i < op_q.size(); i++) begin
      if (op_q[i] == "T") begin
        total_ticks += int'(data_q[i]);
      end
    end
    limit_ns = (2 * total_ticks * TICKS_PER_SECOND + 4 * op_q.size() + 200) * CLK_PERIOD;
    repeat (3) @(posedge clk_50M);
    #2;
    rst_n = 1'b1;
    @(posedge clk_50M);
    #2;
    for (i = 0; i < op_q.size(); i++) begin
      if (op_q[i] == "T") begin
        repeat (int'(data_q[i]) * TICKS_PER_SECOND) @(posedge clk_50M);
        #2;
      end else if (op_q[i] == "W" || op_q[i] == "E" || op_q[i] == "R") begin
        bus_cycle(i);
      end else begin
        $display("unknown operation letter %c in test list", op_q[i]);
        setup_errors++;
      end
    end
    done = 1'b1;
    #1;
    if (setup_errors == 0 && fail_count == 0 && pass_count > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/timer_checker.sv
// Bus response checker
`timescale 1ns/1ps
`default_nettype none

module timer_checker (
  input  logic             clk_50M,
  input  logic             rst_n,
  input  logic             ack,
  input  logic             err,
  input  logic             irq,
  input  wb_pkg::wb_data_t dat_r,
  input  logic [7:0]       exp_op,
  input  wb_pkg::wb_addr_t exp_adr,
  input  wb_pkg::wb_data_t exp_data,
  input  int               exp_slack,
  input  logic             exp_irq,
  input  logic             done,
  output int               pass_count,
  output int               fail_count
);

  import wb_pkg::*;

  int test_num;

  // digit weights from hours tens down to seconds units
  function automatic int bcd_seconds(input wb_data_t v);
    int weight [6];
    int total;
    int d;
    weight = '{36000, 3600, 600, 60, 10, 1};
    total  = 0;
    for (d = 0; d < 6; d++) begin
      total += weight[d] * int'(v[23 - 4 * d -: 4]);
    end
    return total;
  endfunction

  // a running timer may have lost up to exp_slack more seconds
  function automatic logic read_matches(input wb_data_t got);
    int secs;
    int want;
    if (exp_slack == 0) begin
      return got == exp_data;
    end
    secs = bcd_seconds(got);
    want = bcd_seconds(exp_data);
    return (got[31:24] == 8'h00) && (secs <= want) && (secs >= want - exp_slack);
  endfunction

  // outputs settle between edges, so sample on the falling edge
  always @(negedge clk_50M) begin : sample
    logic ok;
    logic want_err;
    if (rst_n && (ack || err)) begin
      ok       = 1'b1;
      want_err = (exp_op == "E");
      test_num++;
      if (err !== want_err) begin
        $display("mismatch at %0t: err got %b expected %b", $time, err, want_err);
        ok = 1'b0;
      end
      if (ack !== !want_err) begin
        $display("mismatch at %0t: ack got %b expected %b", $time, ack, !want_err);
        ok = 1'b0;
      end
      if (irq !== exp_irq) begin
        $display("mismatch at %0t: irq got %b expected %b", $time, irq, exp_irq);
        ok = 1'b0;
      end
      if (exp_op == "R" && !read_matches(dat_r)) begin
        $display("mismatch at %0t: dat_r got %h expected %h", $time, dat_r, exp_data);
        ok = 1'b0;
      end
      if (ok) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("test %0d %c adr %h: %s", test_num, exp_op, exp_adr, ok ? "ok" : "FAILED");
    end
  end

  always @(posedge done) begin
    $display("tests run %0d, passed %0d, failed %0d", test_num, pass_count, fail_count);
  end

endmodule

`default_nettype wire

//--- logic/timer_top.sv
// Timer bank top level
`timescale 1ns/1ps
`default_nettype none

module timer_top #(
  parameter int ticks_per_second = 50000000
) (
  input  logic             clk_50M,
  input  logic             rst_n,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  wb_pkg::wb_addr_t adr,
  input  wb_pkg::wb_sel_t  sel,
  input  wb_pkg::wb_data_t dat_w,
  output wb_pkg::wb_data_t dat_r,
  output logic             ack,
  output logic             err,
  output logic             irq
);

  import wb_pkg::*;
  import timer_pkg::*;

  logic       tick;
  chan_mask_t load;
  chan_mask_t play;
  chan_mask_t stop;
  chan_mask_t clear_mask;
  chan_mask_t counting;
  chan_mask_t ring;
  chan_mask_t pending;
  bcd_time_t  load_time;
  bcd_time_t  remaining_bcd [NUM_CHANNELS];

  tick_gen #(
    .ticks_per_second(ticks_per_second)
  ) tick_gen_i (
    .clk_50M(clk_50M),
    .rst_n  (rst_n),
    .tick   (tick)
  );

  timer_regs timer_regs_i (
    .clk_50M      (clk_50M),
    .rst_n        (rst_n),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .sel          (sel),
    .dat_w        (dat_w),
    .dat_r        (dat_r),
    .ack          (ack),
    .err          (err),
    .load         (load),
    .play         (play),
    .stop         (stop),
    .load_time    (load_time),
    .clear_mask   (clear_mask),
    .remaining_bcd(remaining_bcd),
    .counting     (counting),
    .ring         (ring),
    .pending      (pending)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    timer_channel timer_channel_i (
      .clk_50M      (clk_50M),
      .rst_n        (rst_n),
      .tick         (tick),
      .load         (load[i]),
      .play         (play[i]),
      .stop         (stop[i]),
      .load_time    (load_time),
      .remaining_bcd(remaining_bcd[i]),
      .counting     (counting[i]),
      .ring         (ring[i])
    );
  end

  alarm_collect alarm_collect_i (
    .clk_50M   (clk_50M),
    .rst_n     (rst_n),
    .ring      (ring),
    .clear_mask(clear_mask),
    .pending   (pending),
    .irq       (irq)
  );

endmodule

`default_nettype wire

//--- logic/alarm_collect.sv
// Alarm pending and interrupt
`timescale 1ns/1ps
`default_nettype none

module alarm_collect (
  input  logic               clk_50M,
  input  logic               rst_n,
  input  wb_pkg::chan_mask_t ring,
  input  wb_pkg::chan_mask_t clear_mask,
  output wb_pkg::chan_mask_t pending,
  output logic               irq
);

  import wb_pkg::*;

  chan_mask_t ring_q;
  chan_mask_t ring_rise;
  chan_mask_t pending_nxt;

  assign ring_rise = ring & ~ring_q;

  // a fresh edge beats a clear in the same cycle
  assign pending_nxt = (pending & ~clear_mask) | ring_rise;

  always_ff @(posedge clk_50M or negedge rst_n) begin
    if (!rst_n) begin
      ring_q  <= '0;
      pending <= '0;
      irq     <= 1'b0;
    end else begin
      ring_q  <= ring;
      pending <= pending_nxt;
      irq     <= |pending_nxt;
    end
  end

endmodule

`default_nettype wire

//--- logic/timer_channel.sv
// Count-down timer channel
`timescale 1ns/1ps
`default_nettype none

module timer_channel (
  input  logic                 clk_50M,
  input  logic                 rst_n,
  input  logic                 tick,
  input  logic                 load,
  input  logic                 play,
  input  logic                 stop,
  input  timer_pkg::bcd_time_t load_time,
  output timer_pkg::bcd_time_t remaining_bcd,
  output logic                 counting,
  output logic                 ring
);

  import timer_pkg::*;

  `include "bcd_conv.svh"

  sec_count_t secs;

  always_ff @(posedge clk_50M or negedge rst_n) begin
    if (!rst_n) begin
      secs     <= '0;
      counting <= 1'b0;
      ring     <= 1'b0;
    end else if (load) begin
      secs     <= bcd_to_seconds(load_time);
      counting <= 1'b0;
      ring     <= 1'b0;
    end else if (play) begin
      // nothing left to count
      if (secs != '0) begin
        counting <= 1'b1;
      end
    end else if (stop) begin
      counting <= 1'b0;
    end else if (counting && tick) begin
      secs <= secs - 1'b1;
      if (secs == sec_count_t'(1)) begin
        counting <= 1'b0;
        ring     <= 1'b1;
      end
    end
  end

  // readout lags the binary count by one cycle
  always_ff @(posedge clk_50M or negedge rst_n) begin
    if (!rst_n) begin
      remaining_bcd <= '0;
    end else begin
      remaining_bcd <= seconds_to_bcd(secs);
    end
  end

  a_count_xor_ring: assert property (@(posedge clk_50M) disable iff (!rst_n)
    !(counting && ring))
    else $error("counting and ring both set");

  // load values are screened for BCD range in the register block
  a_secs_range: assert property (@(posedge clk_50M) disable iff (!rst_n)
    secs <= MAX_SECONDS)
    else $error("remaining time above 99:59:59");

endmodule

`default_nettype wire

//--- logic/timer_regs.sv
// Wishbone timer register block
`timescale 1ns/1ps
`default_nettype none

module timer_regs (
  input  logic                  clk_50M,
  input  logic                  rst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  wb_pkg::wb_addr_t      adr,
  input  wb_pkg::wb_sel_t       sel,
  input  wb_pkg::wb_data_t      dat_w,
  output wb_pkg::wb_data_t      dat_r,
  output logic                  ack,
  output logic                  err,
  output wb_pkg::chan_mask_t    load,
  output wb_pkg::chan_mask_t    play,
  output wb_pkg::chan_mask_t    stop,
  output timer_pkg::bcd_time_t  load_time,
  output wb_pkg::chan_mask_t    clear_mask,
  input  timer_pkg::bcd_time_t  remaining_bcd [wb_pkg::NUM_CHANNELS],
  input  wb_pkg::chan_mask_t    counting,
  input  wb_pkg::chan_mask_t    ring,
  input  wb_pkg::chan_mask_t    pending
);

  import wb_pkg::*;
  import timer_pkg::*;

  `include "bcd_conv.svh"

  wb_addr_t          win_idx;
  wb_addr_t          win_off;
  logic [CHAN_W-1:0] chan;
  chan_mask_t        chan_bit;
  logic              in_chan;
  logic              is_time;
  logic              is_ctrl;
  logic              is_pend;
  logic              bad_time;
  logic              req;
  logic              busy;
  wb_data_t          read_word;

  // channel window and register offset
  assign win_idx  = adr / CHAN_STRIDE;
  assign win_off  = adr % CHAN_STRIDE;
  assign chan     = win_idx[CHAN_W-1:0];
  assign chan_bit = chan_mask_t'(1) << chan;
  assign in_chan  = (win_idx < wb_addr_t'(NUM_CHANNELS));
  assign is_time  = in_chan && (win_off == REG_TIME);
  assign is_ctrl  = in_chan && (win_off == REG_CTRL);
  assign is_pend  = (adr == REG_PENDING);

  // busy holds off a second answer until stb drops
  assign req      = cyc && stb && !busy;
  assign bad_time = we && is_time && !bcd_time_valid(dat_w[23:0]);

  always_comb begin
    read_word = '0;
    if (!we) begin
      if (is_time) begin
        read_word = wb_data_t'(remaining_bcd[chan]);
      end else if (is_ctrl) begin
        read_word = wb_data_t'({ring[chan], counting[chan]});
      end else if (is_pend) begin
        read_word = wb_data_t'(pending);
      end
    end
  end

  always_ff @(posedge clk_50M or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      ack        <= 1'b0;
      err        <= 1'b0;
      load       <= '0;
      play       <= '0;
      stop       <= '0;
      clear_mask <= '0;
    end else begin
      if (req) begin
        busy <= 1'b1;
      end else if (!stb) begin
        busy <= 1'b0;
      end
      ack <= req && !bad_time;
      err <= req && bad_time;
      load <= (req && we && is_time && !bad_time) ? chan_bit : '0;
      // stop wins over play
      play <= (req && we && is_ctrl && dat_w[0] && !dat_w[1]) ? chan_bit : '0;
      stop <= (req && we && is_ctrl && dat_w[1]) ? chan_bit : '0;
      clear_mask <= (req && we && is_pend) ? dat_w[NUM_CHANNELS-1:0] : '0;
    end
  end

  always_ff @(posedge clk_50M) begin
    if (req) begin
      load_time <= dat_w[23:0];
      dat_r     <= read_word;
    end
  end

  a_one_resp: assert property (@(posedge clk_50M) disable iff (!rst_n) !(ack && err))
    else $error("ack and err high together");

  a_resp_in_cycle: assert property (@(posedge clk_50M) disable iff (!rst_n)
    (ack || err) |-> (cyc && stb))
    else $error("response without an active bus cycle");

  // only full-word accesses are decoded
  a_full_word: assert property (@(posedge clk_50M) disable iff (!rst_n) req |-> (&sel))
    else $error("partial byte select on timer access");

endmodule

`default_nettype wire

//--- logic/tick_gen.sv
// One second tick prescaler
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
  parameter int ticks_per_second = 50000000
) (
  input  logic clk_50M,
  input  logic rst_n,
  output logic tick
);

  localparam int CNT_W = $clog2(ticks_per_second);

  logic [CNT_W-1:0] cnt;
  logic             last;

  assign last = (cnt == CNT_W'(ticks_per_second - 1));

  always_ff @(posedge clk_50M or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      cnt  <= last ? '0 : cnt + 1'b1;
      tick <= last;
    end
  end

  // channels rely on one decrement per pulse
  a_tick_single: assert property (@(posedge clk_50M) disable iff (!rst_n) tick |=> !tick)
    else $error("tick high on two consecutive cycles");

endmodule

`default_nettype wire

//--- logic/wb_pkg.sv
// Bus and register map
`default_nettype none

package wb_pkg;

  localparam int NUM_CHANNELS = 4;
  localparam int CHAN_W = $clog2(NUM_CHANNELS);

  typedef logic [7:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0] wb_sel_t;
  typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

  // offsets inside one channel window
  localparam wb_addr_t REG_TIME = 8'h00;
  localparam wb_addr_t REG_CTRL = 8'h04;
  localparam wb_addr_t CHAN_STRIDE = 8'h10;

  // global registers past the channel windows
  localparam wb_addr_t REG_PENDING = 8'h40;

endpackage

`default_nettype wire

//--- logic/timer_pkg.sv
// Timer time types
`default_nettype none

package timer_pkg;

  // two BCD digits
  typedef logic [7:0] bcd_byte_t;

  // hours, minutes, seconds as BCD bytes
  typedef logic [23:0] bcd_time_t;

  // remaining time in whole seconds
  typedef logic [18:0] sec_count_t;

  // 99:59:59
  localparam sec_count_t MAX_SECONDS = sec_count_t'(359999);

  localparam sec_count_t SECS_PER_HOUR = sec_count_t'(3600);
  localparam sec_count_t SECS_PER_MIN = sec_count_t'(60);
  localparam sec_count_t DECIMAL_BASE = sec_count_t'(10);

endpackage

`default_nettype wire

//--- include/bcd_conv.svh
// BCD time conversion

// hours tens digit up to 9 keeps hours within 0..99
function automatic logic bcd_time_valid(input bcd_time_t t);
  return (t[23:20] <= 4'd9) && (t[19:16] <= 4'd9) &&
         (t[15:12] <= 4'd5) && (t[11:8] <= 4'd9) &&
         (t[7:4] <= 4'd5) && (t[3:0] <= 4'd9);
endfunction

function automatic sec_count_t bcd_to_seconds(input bcd_time_t t);
  sec_count_t hrs;
  sec_count_t mins;
  sec_count_t secs;
  hrs = sec_count_t'(t[23:20]) * DECIMAL_BASE + sec_count_t'(t[19:16]);
  mins = sec_count_t'(t[15:12]) * DECIMAL_BASE + sec_count_t'(t[11:8]);
  secs = sec_count_t'(t[7:4]) * DECIMAL_BASE + sec_count_t'(t[3:0]);
  return hrs * SECS_PER_HOUR + mins * SECS_PER_MIN + secs;
endfunction

function automatic bcd_time_t seconds_to_bcd(input sec_count_t secs);
  sec_count_t hrs;
  sec_count_t mins;
  sec_count_t rest;
  bcd_byte_t hh;
  bcd_byte_t mm;
  bcd_byte_t ss;
  hrs = secs / SECS_PER_HOUR;
  rest = secs % SECS_PER_HOUR;
  mins = rest / SECS_PER_MIN;
  rest = rest % SECS_PER_MIN;
  hh = {4'(hrs / DECIMAL_BASE), 4'(hrs % DECIMAL_BASE)};
  mm = {4'(mins / DECIMAL_BASE), 4'(mins % DECIMAL_BASE)};
  ss = {4'(rest / DECIMAL_BASE), 4'(rest % DECIMAL_BASE)};
  return {hh, mm, ss};
endfunction
